// File: hw/spi_frame_pkg.sv
`default_nettype none

package spi_frame_pkg;

  // bit 11 of a command frame.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    LOAD    = 3'd1,
    W_SHIFT = 3'd2,
    R_HDR   = 3'd3,
    R_TURN  = 3'd4,
    R_DATA  = 3'd5,
    DONE    = 3'd6
  } master_state_e;

  localparam int CMD_WIDTH_DEF  = 12;
  localparam int READ_WIDTH_DEF = 8;
  localparam int HDR_WIDTH_DEF  = 4; // opcode plus 3-bit address.

endpackage

`default_nettype wire

// File: hw/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

  localparam int CFG_DW = 8;

  typedef enum logic [1:0] {
    REG_CLK_DIV = 2'd0,
    REG_TURN    = 2'd1,
    REG_STATUS  = 2'd2
  } cfg_addr_e;

  localparam logic [CFG_DW-1:0] CLK_DIV_RST = 8'd4;
  localparam logic [CFG_DW-1:0] TURN_RST    = 8'd8;

  // status register layout.
  localparam int STAT_BUSY_BIT = 7;
  localparam int STAT_CNT_W    = 7;

endpackage

`default_nettype wire

// File: hw/spi_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cfg_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cfg_wr,
  input  logic [1:0]                     cfg_addr,
  input  logic [spi_cfg_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [spi_cfg_pkg::CFG_DW-1:0] cfg_rdata,
  input  logic                           busy,
  input  logic                           frame_done,
  output logic [spi_cfg_pkg::CFG_DW-1:0] clk_div,
  output logic [spi_cfg_pkg::CFG_DW-1:0] turn_len
);

  spi_cfg_pkg::cfg_addr_e                addr;
  logic [spi_cfg_pkg::STAT_CNT_W-1:0]    frame_cnt;

  assign addr = spi_cfg_pkg::cfg_addr_e'(cfg_addr);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_div  <= spi_cfg_pkg::CLK_DIV_RST;
      turn_len <= spi_cfg_pkg::TURN_RST;
    end
    else if (cfg_wr)
    begin
      case (addr)
        spi_cfg_pkg::REG_CLK_DIV: clk_div  <= cfg_wdata;
        spi_cfg_pkg::REG_TURN:    turn_len <= cfg_wdata;
        default: ; // status is read-only.
      endcase
    end
  end

  // wraps at 128.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_cnt <= '0;
    end
    else if (frame_done)
    begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  always_comb
  begin
    cfg_rdata = '0;
    case (addr)
      spi_cfg_pkg::REG_CLK_DIV: cfg_rdata = clk_div;
      spi_cfg_pkg::REG_TURN:    cfg_rdata = turn_len;
      spi_cfg_pkg::REG_STATUS:
      begin
        cfg_rdata[spi_cfg_pkg::STAT_BUSY_BIT]       = busy;
        cfg_rdata[spi_cfg_pkg::STAT_CNT_W-1:0]      = frame_cnt;
      end
      default: cfg_rdata = '0; // unmapped.
    endcase
  end

endmodule

`default_nettype wire

// File: hw/spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           sclk_en,
  input  logic [spi_cfg_pkg::CFG_DW-1:0] clk_div,
  output logic                           sclk,
  output logic                           sclk_rise,
  output logic                           sclk_fall
);

  logic [spi_cfg_pkg::CFG_DW-1:0] cnt;
  logic                           half_done;

  // >= so a smaller divider written mid-frame applies at the next half period.
  assign half_done = sclk_en && (cnt >= clk_div);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt       <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!sclk_en)
    begin
      cnt       <= '0; // next window gets a full first half.
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      sclk_rise <= half_done && !sclk; // ticks line up with the new level.
      sclk_fall <= half_done && sclk;
      if (half_done)
      begin
        cnt  <= '0;
        sclk <= ~sclk;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_master #(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  parameter int HDR_WIDTH  = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [CMD_WIDTH-1:0]           cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [READ_WIDTH-1:0]          read_data,
  output logic                           read_vld,
  input  logic [spi_cfg_pkg::CFG_DW-1:0] turn_len,
  output logic                           sclk_en,
  input  logic                           sclk_lvl,
  input  logic                           sclk_rise,
  input  logic                           sclk_fall,
  output logic                           busy,
  output logic                           frame_done,
  output logic                           sclk,
  output logic                           cs_n,
  output logic                           mosi,
  input  logic                           miso
);

  localparam int CNT_W = $clog2(CMD_WIDTH + 1);

  spi_frame_pkg::master_state_e   state;
  spi_frame_pkg::spi_op_e         op;
  spi_frame_pkg::spi_op_e         op_dec;
  logic [CMD_WIDTH-1:0]           tx_sr;
  logic [READ_WIDTH-1:0]          rx_sr;
  logic [CNT_W-1:0]               bit_cnt;
  logic [spi_cfg_pkg::CFG_DW-1:0] turn_cnt;
  logic [spi_cfg_pkg::CFG_DW-1:0] turn_max;
  logic                           accept;
  logic                           last_fall;

  assign accept   = cmd_vld && cmd_rdy;
  assign op_dec   = spi_frame_pkg::spi_op_e'(tx_sr[CMD_WIDTH-1]);
  assign turn_max = (turn_len == '0) ? spi_cfg_pkg::CFG_DW'(1) : turn_len; // 0 acts as 1.
  assign busy     = (state != spi_frame_pkg::IDLE);
  assign sclk     = sclk_lvl & ~cs_n; // idle low outside a window.

  assign sclk_en = (state == spi_frame_pkg::W_SHIFT) ||
                   (state == spi_frame_pkg::R_HDR)   ||
                   (state == spi_frame_pkg::R_DATA);

  // one counter for all windows, only the end count differs.
  always_comb
  begin
    case (state)
      spi_frame_pkg::W_SHIFT: last_fall = sclk_fall && (bit_cnt == CNT_W'(CMD_WIDTH - 1));
      spi_frame_pkg::R_HDR:   last_fall = sclk_fall && (bit_cnt == CNT_W'(HDR_WIDTH - 1));
      spi_frame_pkg::R_DATA:  last_fall = sclk_fall && (bit_cnt == CNT_W'(READ_WIDTH - 1));
      default:                last_fall = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= spi_frame_pkg::IDLE;
      op         <= spi_frame_pkg::OP_READ;
      cmd_rdy    <= 1'b1;
      cs_n       <= 1'b1;
      mosi       <= 1'b0;
      read_vld   <= 1'b0;
      frame_done <= 1'b0;
      bit_cnt    <= '0;
      turn_cnt   <= '0;
    end
    else
    begin
      read_vld   <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        spi_frame_pkg::IDLE:
        begin
          if (accept)
          begin
            cmd_rdy <= 1'b0;
            state   <= spi_frame_pkg::LOAD;
          end
        end
        spi_frame_pkg::LOAD:
        begin
          op      <= op_dec;
          cs_n    <= 1'b0;
          mosi    <= tx_sr[CMD_WIDTH-1]; // first bit ready as cs_n falls.
          bit_cnt <= '0;
          state   <= (op_dec == spi_frame_pkg::OP_WRITE) ? spi_frame_pkg::W_SHIFT
                                                         : spi_frame_pkg::R_HDR;
        end
        spi_frame_pkg::W_SHIFT,
        spi_frame_pkg::R_HDR:
        begin
          if (last_fall)
          begin
            cs_n     <= 1'b1;
            mosi     <= 1'b0;
            bit_cnt  <= '0;
            turn_cnt <= '0;
            state    <= (state == spi_frame_pkg::W_SHIFT) ? spi_frame_pkg::DONE
                                                          : spi_frame_pkg::R_TURN;
          end
          else if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= tx_sr[CMD_WIDTH-2];
          end
        end
        spi_frame_pkg::R_TURN:
        begin
          if (turn_cnt == turn_max - 1'b1)
          begin
            cs_n  <= 1'b0;
            state <= spi_frame_pkg::R_DATA;
          end
          else
          begin
            turn_cnt <= turn_cnt + 1'b1;
          end
        end
        spi_frame_pkg::R_DATA:
        begin
          if (last_fall)
          begin
            cs_n    <= 1'b1;
            bit_cnt <= '0;
            state   <= spi_frame_pkg::DONE;
          end
          else if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        spi_frame_pkg::DONE:
        begin
          frame_done <= 1'b1;
          read_vld   <= (op == spi_frame_pkg::OP_READ);
          cmd_rdy    <= 1'b1;
          state      <= spi_frame_pkg::IDLE;
        end
        default: state <= spi_frame_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == spi_frame_pkg::IDLE && accept)
    begin
      tx_sr <= cmd_in;
    end
    else if ((state == spi_frame_pkg::W_SHIFT || state == spi_frame_pkg::R_HDR) && sclk_fall)
    begin
      tx_sr <= tx_sr << 1;
    end
    if (state == spi_frame_pkg::R_DATA && sclk_rise)
    begin
      rx_sr <= {rx_sr[READ_WIDTH-2:0], miso}; // msb first.
    end
    if (state == spi_frame_pkg::DONE && op == spi_frame_pkg::OP_READ)
    begin
      read_data <= rx_sr; // held until next read.
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_top #(
  parameter int CMD_WIDTH  = spi_frame_pkg::CMD_WIDTH_DEF,
  parameter int READ_WIDTH = spi_frame_pkg::READ_WIDTH_DEF,
  parameter int HDR_WIDTH  = spi_frame_pkg::HDR_WIDTH_DEF
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [CMD_WIDTH-1:0]           cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [READ_WIDTH-1:0]          read_data,
  output logic                           read_vld,
  input  logic                           cfg_wr,
  input  logic [1:0]                     cfg_addr,
  input  logic [spi_cfg_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [spi_cfg_pkg::CFG_DW-1:0] cfg_rdata,
  output logic                           sclk,
  output logic                           cs_n,
  output logic                           mosi,
  input  logic                           miso
);

  logic [spi_cfg_pkg::CFG_DW-1:0] clk_div;
  logic [spi_cfg_pkg::CFG_DW-1:0] turn_len;
  logic                           busy;
  logic                           frame_done;
  logic                           sclk_en;
  logic                           sclk_lvl;
  logic                           sclk_rise;
  logic                           sclk_fall;

  spi_cfg_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .busy       (busy),
    .frame_done (frame_done),
    .clk_div    (clk_div),
    .turn_len   (turn_len)
  );

  spi_sclk_gen u_sclk (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .clk_div   (clk_div),
    .sclk      (sclk_lvl),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_cmd_master #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH),
    .HDR_WIDTH  (HDR_WIDTH)
  ) u_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .turn_len   (turn_len),
    .sclk_en    (sclk_en),
    .sclk_lvl   (sclk_lvl),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall),
    .busy       (busy),
    .frame_done (frame_done),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso)
  );

endmodule

`default_nettype wire

// File: tb/spi_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_props (
  input logic                         clk,
  input logic                         rst_n,
  input spi_frame_pkg::master_state_e state,
  input logic                         sclk,
  input logic                         cs_n,
  input logic                         cmd_rdy,
  input logic                         read_vld
);

  assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
    else $error("read_vld high for two cycles in a row");

  assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> !cmd_rdy)
    else $error("cmd_rdy high inside a chip-select window");

  // gap after every window.
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == spi_frame_pkg::R_TURN || state == spi_frame_pkg::DONE) |-> cs_n)
    else $error("cs_n low between windows");

endmodule

bind spi_cmd_master spi_ctrl_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .sclk     (sclk_lvl),
  .cs_n     (cs_n),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

`default_nettype wire

// File: tb/tb_spi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_ctrl;

  localparam int CMD_W   = spi_frame_pkg::CMD_WIDTH_DEF;
  localparam int RD_W    = spi_frame_pkg::READ_WIDTH_DEF;
  localparam int HDR_W   = spi_frame_pkg::HDR_WIDTH_DEF;
  localparam int DW      = spi_cfg_pkg::CFG_DW;
  localparam int TIMEOUT = 1000; // clk cycles per wait.

  logic             clk;
  logic             rst_n;
  logic [CMD_W-1:0] cmd_in;
  logic             cmd_vld;
  logic             cmd_rdy;
  logic [RD_W-1:0]  read_data;
  logic             read_vld;
  logic             cfg_wr;
  logic [1:0]       cfg_addr;
  logic [DW-1:0]    cfg_wdata;
  logic [DW-1:0]    cfg_rdata;
  logic             sclk;
  logic             cs_n;
  logic             mosi;
  logic             miso;

  logic [RD_W-1:0]  slave_rom [8] = '{8'hA5, 8'h3C, 8'h96, 8'h0F, 8'hE1, 8'h5A, 8'hC3, 8'h7E};
  logic [RD_W-1:0]  slave_tx = '0;
  logic [15:0]      rx_bits = '0;
  int               rx_len = 0;
  logic             in_win = 1'b0;
  logic             hdr_seen = 1'b0; // last window was a read header.
  logic [2:0]       hdr_addr = '0;
  int               hi_cycles = 0;
  int               win_count = 0;
  int               win_len [$];
  logic [15:0]      win_val [$];
  int               win_gap [$];   // cs_n high cycles before each window.
  logic [15:0]      lfsr;
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  int               bad_tests = 0;
  int               frames = 0;

  spi_ctrl_top u_dut (.*);

  assign miso = slave_tx[RD_W-1];

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // mode 0 slave.
  always @(negedge cs_n or posedge cs_n or posedge sclk or negedge sclk)
  begin
    if (cs_n === 1'b0 && !in_win)
    begin
      in_win   = 1'b1;
      rx_bits  = '0;
      rx_len   = 0;
      win_gap.push_back(hi_cycles);
      slave_tx = hdr_seen ? slave_rom[hdr_addr] : '0;
      hdr_seen = 1'b0;
    end
    else if (cs_n === 1'b0 && sclk === 1'b1)
    begin
      rx_bits = {rx_bits[14:0], mosi};
      rx_len++;
    end
    else if (cs_n === 1'b0 && sclk === 1'b0)
      slave_tx = slave_tx << 1; // next bit after each fall.
    else if (cs_n === 1'b1 && in_win)
    begin
      in_win = 1'b0;
      win_len.push_back(rx_len);
      win_val.push_back(rx_bits);
      win_count++;
      hdr_seen = (rx_len == HDR_W) && (rx_bits[HDR_W-1] == spi_frame_pkg::OP_READ);
      hdr_addr = rx_bits[2:0];
    end
  end

  always @(negedge clk)
  begin
    hi_cycles = cs_n ? hi_cycles + 1 : 0;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1.
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    repeat (n)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("** Error: %s at %0t", msg, $time);
  endtask

  task automatic check_cmd(input string name, input logic [CMD_W-1:0] got, want);
    checks++;
    if (got !== want)
      report_fail($sformatf("%s = 0x%h, expected 0x%h", name, got, want));
  endtask

  task automatic check_rdata(input string name, input logic [RD_W-1:0] got, want);
    checks++;
    if (got !== want)
      report_fail($sformatf("%s = 0x%h, expected 0x%h", name, got, want));
  endtask

  task automatic check_cfg(input string name, input logic [DW-1:0] got, want);
    checks++;
    if (got !== want)
      report_fail($sformatf("%s = 0x%h, expected 0x%h", name, got, want));
  endtask

  task automatic check_pin(input string name, input logic got, want);
    checks++;
    if (got !== want)
      report_fail($sformatf("%s = 0x%h, expected 0x%h", name, got, want));
  endtask

  task automatic check_window(input int idx, input int len, input logic cmp_val,
                              input logic [CMD_W-1:0] want);
    if (idx >= win_count)
      report_fail($sformatf("slave never saw window %0d", idx));
    else if (win_len[idx] != len)
      report_fail($sformatf("window %0d had %0d sclk pulses, not %0d", idx, win_len[idx], len));
    else if (cmp_val)
      check_cmd("mosi", CMD_W'(win_val[idx]), want);
  endtask

  task automatic write_reg(input spi_cfg_pkg::cfg_addr_e a, input logic [DW-1:0] d);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_wr    = 1'b0;
  endtask

  task automatic read_reg(input spi_cfg_pkg::cfg_addr_e a, output logic [DW-1:0] v);
    @(negedge clk);
    cfg_addr = a;
    #2;
    v = cfg_rdata;
  endtask

  task automatic send_cmd(input logic [CMD_W-1:0] cmd);
    int n;
    n = 0;
    @(negedge clk);
    while (cmd_rdy !== 1'b1 && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
      report_fail("cmd_rdy stayed low, command not sent");
    else
    begin
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      frames++;
    end
  endtask

  task automatic wait_frame_end(output logic got_vld, output logic [RD_W-1:0] got_data);
    int n;
    n        = 0;
    got_vld  = 1'b0;
    got_data = '0;
    while (cmd_rdy !== 1'b1 && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (read_vld === 1'b1)
      begin
        got_vld  = 1'b1;
        got_data = read_data;
      end
    end
    if (cmd_rdy !== 1'b1)
      report_fail("frame never finished, cmd_rdy stayed low");
  endtask

  task automatic reset_values();
    logic [DW-1:0] v;
    check_pin("cs_n", cs_n, 1'b1);
    check_pin("sclk", sclk, 1'b0);
    check_pin("cmd_rdy", cmd_rdy, 1'b1);
    check_pin("read_vld", read_vld, 1'b0);
    read_reg(spi_cfg_pkg::REG_CLK_DIV, v);
    check_cfg("clk_div", v, spi_cfg_pkg::CLK_DIV_RST);
    read_reg(spi_cfg_pkg::REG_TURN, v);
    check_cfg("turn_len", v, spi_cfg_pkg::TURN_RST);
    read_reg(spi_cfg_pkg::REG_STATUS, v);
    check_cfg("status", v, '0);
  endtask

  task automatic write_frames();
    logic [15:0]      r;
    logic [CMD_W-1:0] cmd;
    logic             vld;
    logic [RD_W-1:0]  rd;
    int               w;
    int               i;
    for (i = 0; i < 6; i++)
    begin
      if (i == 0)
        write_reg(spi_cfg_pkg::REG_CLK_DIV, 8'd4);
      if (i == 3)
        write_reg(spi_cfg_pkg::REG_CLK_DIV, 8'd1);
      take_bits(CMD_W - 1, r);
      cmd = {spi_frame_pkg::OP_WRITE, r[CMD_W-2:0]};
      w   = win_count;
      send_cmd(cmd);
      wait_frame_end(vld, rd);
      if (win_count != w + 1)
        report_fail($sformatf("write frame opened %0d windows, not 1", win_count - w));
      check_window(w, CMD_W, 1'b1, cmd);
      check_pin("read_vld", vld, 1'b0);
    end
  endtask

  task automatic read_frames();
    logic [CMD_W-1:0] cmd;
    logic             vld;
    logic [RD_W-1:0]  rd;
    int               w;
    int               a;
    int               k;
    int               turn;
    for (k = 0; k < 2; k++)
    begin
      turn = (k == 0) ? 3 : 0;
      write_reg(spi_cfg_pkg::REG_TURN, DW'(turn));
      for (a = 0; a < 8; a++)
      begin
        cmd = {spi_frame_pkg::OP_READ, 3'(a), 8'h00};
        w   = win_count;
        send_cmd(cmd);
        wait_frame_end(vld, rd);
        if (win_count != w + 2)
          report_fail($sformatf("read frame opened %0d windows, not 2", win_count - w));
        check_window(w, HDR_W, 1'b1, CMD_W'(cmd[CMD_W-1 -: HDR_W]));
        check_window(w + 1, RD_W, 1'b0, '0);
        if (!vld)
          report_fail($sformatf("no read_vld pulse for address %0d", a));
        else
          check_rdata("read_data", rd, slave_rom[a]);
        if (win_count > w + 1)
          check_cfg("turn_gap", DW'(win_gap[w+1]), DW'((turn == 0) ? 1 : turn));
      end
    end
  endtask

  task automatic busy_and_reject();
    logic [15:0]      r;
    logic [CMD_W-1:0] cmd;
    logic [DW-1:0]    v;
    logic             vld;
    logic [RD_W-1:0]  rd;
    int               w;
    take_bits(CMD_W - 1, r);
    cmd = {spi_frame_pkg::OP_WRITE, r[CMD_W-2:0]};
    w   = win_count;
    send_cmd(cmd);
    read_reg(spi_cfg_pkg::REG_STATUS, v);
    check_pin("status_busy", v[7], 1'b1);
    @(negedge clk);
    check_pin("cmd_rdy", cmd_rdy, 1'b0);
    cmd_in  = ~cmd;
    cmd_vld = 1'b1; // must be dropped by the DUT.
    @(negedge clk);
    cmd_vld = 1'b0;
    wait_frame_end(vld, rd);
    repeat (2 * CMD_W) @(negedge clk);
    if (win_gap.size() != w + 1)
      report_fail($sformatf("rejected command still gave %0d windows", win_gap.size() - w));
    check_window(w, CMD_W, 1'b1, cmd);
    check_pin("cmd_rdy", cmd_rdy, 1'b1);
  endtask

  task automatic frame_counter();
    logic [DW-1:0] v;
    read_reg(spi_cfg_pkg::REG_STATUS, v);
    check_cfg("status", v, DW'(frames % 128));
    write_reg(spi_cfg_pkg::REG_STATUS, 8'h5A);
    read_reg(spi_cfg_pkg::REG_STATUS, v);
    check_cfg("status", v, DW'(frames % 128));
  endtask

  task automatic log_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("test %s: ok", name);
    else
    begin
      bad_tests++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  initial
  begin
    int e;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    lfsr      = 16'd27720;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    e = errors;
    reset_values();
    log_test("reset_values", e);
    e = errors;
    write_frames();
    log_test("write_frames", e);
    e = errors;
    read_frames();
    log_test("read_frames", e);
    e = errors;
    busy_and_reject();
    log_test("busy_and_reject", e);
    e = errors;
    frame_counter();
    log_test("frame_counter", e);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, bad_tests, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/spi_frame_pkg.sv
hw/spi_cfg_pkg.sv
hw/spi_cfg_regs.sv
hw/spi_sclk_gen.sv
hw/spi_cmd_master.sv
hw/spi_ctrl_top.sv
tb/spi_ctrl_props.sv
tb/tb_spi_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="FAIL: see errors above"

verilator --binary --assert -Wno-fatal --top-module tb_spi_ctrl \
  -f flist.f --Mdir obj_dir -o tb_spi_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_spi_ctrl_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "$fail_msg" "$log"; then
  echo "simulation reported failures, see $log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
